// File: rtl/sram_fifo_pkg.sv
`default_nettype none

package sram_fifo_pkg;

    // sram geometry.
    localparam int SRAM_ADDR_W = 10;

    typedef logic [SRAM_ADDR_W-1:0] sram_addr_t;
    // one extra wrap bit to tell full from empty.
    typedef logic [SRAM_ADDR_W:0]   ptr_t;

    typedef logic [15:0] half_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;

    // fill level in halfwords, spread over three host registers.
    typedef logic [20:0] fill_t;
    typedef logic [15:0] bus_addr_t;
    typedef logic [7:0]  err_cnt_t;

    // host bus register map.
    localparam bus_addr_t REG_SOFT_RST = 16'd0;
    localparam bus_addr_t REG_FILL_0   = 16'd1;
    localparam bus_addr_t REG_FILL_1   = 16'd2;
    localparam bus_addr_t REG_FILL_2   = 16'd3;
    localparam bus_addr_t REG_READ_ERR = 16'd4;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_FETCH,
        RD_HIGH,
        RD_LOW
    } reader_state_t;

endpackage

`default_nettype wire

// File: rtl/word_splitter.sv
`default_nettype none

module word_splitter (
    input  logic                 BUS_CLK,
    input  logic                 RST,

    input  logic                 fifo_empty,
    input  sram_fifo_pkg::word_t fifo_data,
    output logic                 fifo_pop,

    output logic                 hw_valid,
    output sram_fifo_pkg::half_t hw_data,
    input  logic                 hw_ready
);

    // set while the low half of the current word is on offer.
    logic low_half;
    logic hw_xfer;

    assign hw_valid = ~fifo_empty;
    assign hw_xfer  = hw_valid && hw_ready;

    // high half goes out first.
    assign hw_data = low_half ? fifo_data[15:0] : fifo_data[31:16];

    // the word is done once its low half is taken.
    assign fifo_pop = hw_xfer && low_half;

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            low_half <= 1'b0;
        end else if (hw_xfer) begin
            low_half <= ~low_half;
        end
    end

endmodule

`default_nettype wire

// File: rtl/sram_ring_ctrl.sv
`default_nettype none

module sram_ring_ctrl (
    input  logic                      BUS_CLK,
    input  logic                      RST,

    // write side, from the splitter.
    input  logic                      hw_valid,
    input  sram_fifo_pkg::half_t      hw_data,
    output logic                      hw_ready,

    // read side, from the byte reader.
    input  logic                      rd_req,
    output logic                      rd_valid,
    output sram_fifo_pkg::half_t      rd_data,

    // external sram.
    output sram_fifo_pkg::sram_addr_t sram_addr,
    output sram_fifo_pkg::half_t      sram_wdata,
    input  sram_fifo_pkg::half_t      sram_rdata,
    output logic                      sram_we,
    output logic                      sram_oe,

    output sram_fifo_pkg::fill_t      occupancy
);

    import sram_fifo_pkg::*;

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    ptr_t ptr_diff;

    logic empty;
    logic full;
    logic rd_grant;
    logic wr_grant;

    // same index, wrap bits equal or not.
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[SRAM_ADDR_W] != rd_ptr[SRAM_ADDR_W]) &&
                   (wr_ptr[SRAM_ADDR_W-1:0] == rd_ptr[SRAM_ADDR_W-1:0]);

    // one sram access per cycle, reads win.
    assign rd_grant = rd_req && !empty;
    assign hw_ready = !full && !rd_grant;
    assign wr_grant = hw_valid && hw_ready;

    assign rd_valid = rd_grant;
    assign rd_data  = sram_rdata;

    always_comb begin
        if (rd_grant) begin
            sram_addr = rd_ptr[SRAM_ADDR_W-1:0];
        end else begin
            sram_addr = wr_ptr[SRAM_ADDR_W-1:0];
        end
    end

    assign sram_wdata = hw_data;
    assign sram_we    = wr_grant;
    assign sram_oe    = rd_grant;

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            wr_ptr <= '0;
        end else if (wr_grant) begin
            wr_ptr <= wr_ptr + ptr_t'(1);
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            rd_ptr <= '0;
        end else if (rd_grant) begin
            rd_ptr <= rd_ptr + ptr_t'(1);
        end
    end

    // modulo difference, wrap bit makes a full ring read as the depth.
    assign ptr_diff  = wr_ptr - rd_ptr;
    assign occupancy = fill_t'(ptr_diff);

endmodule

`default_nettype wire

// File: rtl/byte_reader.sv
`default_nettype none

module byte_reader (
    input  logic                    BUS_CLK,
    input  logic                    RST,

    output logic                    rd_req,
    input  logic                    rd_valid,
    input  sram_fifo_pkg::half_t    rd_data,

    input  logic                    usb_read,
    output sram_fifo_pkg::byte_t    usb_data,
    output logic                    usb_valid,

    output logic                    holding,
    output sram_fifo_pkg::err_cnt_t err_count
);

    import sram_fifo_pkg::*;

    reader_state_t state;
    reader_state_t state_next;

    // halfword being served.
    half_t hw_buf;
    logic  has_bytes;

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            state <= RD_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            // one quiet cycle out of reset.
            RD_IDLE: begin
                state_next = RD_FETCH;
            end
            RD_FETCH: begin
                if (rd_valid) begin
                    state_next = RD_HIGH;
                end
            end
            RD_HIGH: begin
                if (usb_read) begin
                    state_next = RD_LOW;
                end
            end
            RD_LOW: begin
                if (usb_read) begin
                    state_next = RD_FETCH;
                end
            end
            default: begin
                state_next = RD_IDLE;
            end
        endcase
    end

    assign rd_req = (state == RD_FETCH);

    always_ff @(posedge BUS_CLK) begin
        if (rd_req && rd_valid) begin
            hw_buf <= rd_data;
        end
    end

    assign has_bytes = (state == RD_HIGH) || (state == RD_LOW);
    assign usb_valid = has_bytes;
    assign holding   = has_bytes;

    // high byte first.
    assign usb_data = (state == RD_LOW) ? hw_buf[7:0] : hw_buf[15:8];

    // saturating count of reads with nothing on offer.
    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            err_count <= '0;
        end else if (usb_read && !usb_valid && err_count != 8'hff) begin
            err_count <= err_count + err_cnt_t'(1);
        end
    end

endmodule

`default_nettype wire

// File: rtl/conf_regs.sv
`default_nettype none

module conf_regs (
    input  logic                     BUS_CLK,
    input  logic                     RST,

    input  sram_fifo_pkg::bus_addr_t bus_addr,
    input  logic                     bus_wr,
    input  logic                     bus_rd,
    output sram_fifo_pkg::byte_t     bus_data_out,

    input  sram_fifo_pkg::fill_t     occupancy,
    input  logic                     holding,
    input  sram_fifo_pkg::err_cnt_t  err_count,

    output logic                     soft_rst,
    output logic                     fifo_not_empty,
    output logic                     fifo_read_error
);

    import sram_fifo_pkg::*;

    fill_t fill;

    // ring contents plus the halfword parked in the reader.
    assign fill = occupancy + fill_t'(holding);

    always_comb begin
        bus_data_out = '0;
        if (bus_rd) begin
            case (bus_addr)
                REG_FILL_0:   bus_data_out = fill[7:0];
                REG_FILL_1:   bus_data_out = fill[15:8];
                REG_FILL_2:   bus_data_out = {3'b000, fill[20:16]};
                REG_READ_ERR: bus_data_out = err_count;
                default:      bus_data_out = '0;
            endcase
        end
    end

    // any write to address 0, data ignored.
    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            soft_rst <= 1'b0;
        end else begin
            soft_rst <= bus_wr && (bus_addr == REG_SOFT_RST);
        end
    end

    assign fifo_not_empty  = (fill != '0);
    assign fifo_read_error = (err_count != '0);

endmodule

`default_nettype wire

// File: rtl/sram_fifo_top.sv
`default_nettype none

module sram_fifo_top (
    input  logic                      BUS_CLK,
    input  logic                      RST,

    // host bus.
    input  sram_fifo_pkg::bus_addr_t  bus_addr,
    input  sram_fifo_pkg::byte_t      bus_data_in,
    input  logic                      bus_rd,
    input  logic                      bus_wr,
    output sram_fifo_pkg::byte_t      bus_data_out,

    // source fifo.
    input  logic                      fifo_empty,
    input  sram_fifo_pkg::word_t      fifo_data,
    output logic                      fifo_pop,

    // external sram.
    output sram_fifo_pkg::sram_addr_t sram_addr,
    output sram_fifo_pkg::half_t      sram_wdata,
    input  sram_fifo_pkg::half_t      sram_rdata,
    output logic                      sram_we,
    output logic                      sram_oe,

    // usb side.
    input  logic                      usb_read,
    output sram_fifo_pkg::byte_t      usb_data,
    output logic                      usb_valid,

    output logic                      fifo_not_empty,
    output logic                      fifo_read_error
);

    import sram_fifo_pkg::*;

    logic     rst_int;
    logic     soft_rst;

    logic     hw_valid;
    logic     hw_ready;
    half_t    hw_data;

    logic     rd_req;
    logic     rd_valid;
    half_t    rd_data;

    fill_t    occupancy;
    logic     holding;
    err_cnt_t err_count;

    // bus_data_in is not decoded, the soft reset fires on any write value.
    assign rst_int = RST | soft_rst;

    word_splitter i_word_splitter (
        .BUS_CLK    (BUS_CLK),
        .RST        (rst_int),
        .fifo_empty (fifo_empty),
        .fifo_data  (fifo_data),
        .fifo_pop   (fifo_pop),
        .hw_valid   (hw_valid),
        .hw_data    (hw_data),
        .hw_ready   (hw_ready)
    );

    sram_ring_ctrl i_sram_ring_ctrl (
        .BUS_CLK    (BUS_CLK),
        .RST        (rst_int),
        .hw_valid   (hw_valid),
        .hw_data    (hw_data),
        .hw_ready   (hw_ready),
        .rd_req     (rd_req),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .sram_addr  (sram_addr),
        .sram_wdata (sram_wdata),
        .sram_rdata (sram_rdata),
        .sram_we    (sram_we),
        .sram_oe    (sram_oe),
        .occupancy  (occupancy)
    );

    byte_reader i_byte_reader (
        .BUS_CLK   (BUS_CLK),
        .RST       (rst_int),
        .rd_req    (rd_req),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .usb_read  (usb_read),
        .usb_data  (usb_data),
        .usb_valid (usb_valid),
        .holding   (holding),
        .err_count (err_count)
    );

    // runs on the board reset so the soft reset pulse clears itself.
    conf_regs i_conf_regs (
        .BUS_CLK         (BUS_CLK),
        .RST             (RST),
        .bus_addr        (bus_addr),
        .bus_wr          (bus_wr),
        .bus_rd          (bus_rd),
        .bus_data_out    (bus_data_out),
        .occupancy       (occupancy),
        .holding         (holding),
        .err_count       (err_count),
        .soft_rst        (soft_rst),
        .fifo_not_empty  (fifo_not_empty),
        .fifo_read_error (fifo_read_error)
    );

endmodule

`default_nettype wire

// File: testbench/sram_model.sv
`default_nettype none

module sram_model (
    input  logic                      BUS_CLK,
    input  sram_fifo_pkg::sram_addr_t addr,
    input  sram_fifo_pkg::half_t      wdata,
    output sram_fifo_pkg::half_t      rdata,
    input  logic                      we,
    input  logic                      oe
);

    timeunit 1ns;
    timeprecision 1ps;

    import sram_fifo_pkg::*;

    localparam int DEPTH = 1 << SRAM_ADDR_W;

    half_t mem [DEPTH];

    // power-up garbage, distinct per address.
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = half_t'(i * 40503) ^ 16'ha5c3;
        end
    end

    always @(posedge BUS_CLK) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // asynchronous read while output enable is high.
    assign rdata = oe ? mem[addr] : '0;

endmodule

`default_nettype wire

// File: testbench/sram_fifo_props.sv
`default_nettype none

module sram_fifo_props (
    input logic BUS_CLK,
    input logic RST,
    input logic sram_we,
    input logic sram_oe,
    input logic fifo_pop,
    input logic fifo_empty,
    input logic usb_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    // one sram access per cycle.
    sram_one_access: assert property (@(posedge BUS_CLK) !(sram_we && sram_oe))
        else $error("sram write and read strobes high together");

    no_pop_when_empty: assert property (@(posedge BUS_CLK) disable iff (RST)
        fifo_pop |-> !fifo_empty)
        else $error("source popped while empty");

    quiet_after_reset: assert property (@(posedge BUS_CLK) RST |=> !usb_valid)
        else $error("usb_valid high right after reset");

endmodule

bind sram_fifo_top sram_fifo_props i_props (
    .BUS_CLK    (BUS_CLK),
    .RST        (RST),
    .sram_we    (sram_we),
    .sram_oe    (sram_oe),
    .fifo_pop   (fifo_pop),
    .fifo_empty (fifo_empty),
    .usb_valid  (usb_valid)
);

`default_nettype wire

// File: testbench/tb_sram_fifo.sv
`default_nettype none

module tb_sram_fifo;

    timeunit 1ns;
    timeprecision 1ps;

    import sram_fifo_pkg::*;

    logic       BUS_CLK;
    logic       RST;
    bus_addr_t  bus_addr;
    byte_t      bus_data_in;
    byte_t      bus_data_out;
    logic       bus_rd;
    logic       bus_wr;
    logic       fifo_empty;
    word_t      fifo_data;
    logic       fifo_pop;
    sram_addr_t sram_addr;
    half_t      sram_wdata;
    half_t      sram_rdata;
    logic       sram_we;
    logic       sram_oe;
    logic       usb_read;
    byte_t      usb_data;
    logic       usb_valid;
    logic       fifo_not_empty;
    logic       fifo_read_error;

    // one row per test with name, words loaded, reads issued and expected value.
    localparam int ROWS = 6;
    string t_name [ROWS] = '{"reset", "order", "fill", "full", "underflow", "soft_reset"};
    int    t_words[ROWS] = '{0, 8, 6, 513, 0, 5};
    int    t_reads[ROWS] = '{0, 32, 5, 2052, 300, 12};
    int    t_exp  [ROWS] = '{0, 0, 12, 1025, 255, 0};

    word_t       src_q[$];
    byte_t       exp_q[$];
    logic        pop_seen;
    int          pop_cnt;
    int          errors;
    int          timeouts;
    int unsigned lcg_state;

    sram_fifo_top i_dut (.*);

    sram_model i_sram (
        .BUS_CLK (BUS_CLK),
        .addr    (sram_addr),
        .wdata   (sram_wdata),
        .rdata   (sram_rdata),
        .we      (sram_we),
        .oe      (sram_oe)
    );

    always #5 BUS_CLK = ~BUS_CLK;

    // source model advances one word per pop.
    always @(posedge BUS_CLK) begin
        pop_seen <= fifo_pop;
        if (fifo_pop) begin
            pop_cnt <= pop_cnt + 1;
        end
    end

    always @(negedge BUS_CLK) begin
        if (pop_seen && src_q.size() > 0) begin
            void'(src_q.pop_front());
        end
        fifo_empty <= (src_q.size() == 0);
        fifo_data  <= (src_q.size() > 0) ? src_q[0] : '0;
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_byte(string name, byte_t exp, byte_t act);
        if (exp !== act) begin
            $display("FAIL %s: expected %02h, got %02h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_fill(string name, fill_t exp, fill_t act);
        if (exp !== act) begin
            $display("FAIL %s: expected fill %0d, got %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_err(string name, err_cnt_t exp, err_cnt_t act);
        if (exp !== act) begin
            $display("FAIL %s: expected error count %0d, got %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic read_reg(bus_addr_t addr, output byte_t val);
        @(negedge BUS_CLK);
        bus_addr = addr;
        bus_rd   = 1'b1;
        #1;
        val = bus_data_out;
    endtask

    task automatic read_fill(output fill_t val);
        byte_t b0;
        byte_t b1;
        byte_t b2;
        read_reg(REG_FILL_0, b0);
        read_reg(REG_FILL_1, b1);
        read_reg(REG_FILL_2, b2);
        val = fill_t'({b2, b1, b0});
    endtask

    task automatic load_words(int n);
        word_t w;
        for (int i = 0; i < n; i++) begin
            w = lcg_next();
            src_q.push_back(w);
            exp_q.push_back(w[31:24]);
            exp_q.push_back(w[23:16]);
            exp_q.push_back(w[15:8]);
            exp_q.push_back(w[7:0]);
        end
    endtask

    task automatic wait_usb_valid(string name);
        int n;
        n = 0;
        while (!usb_valid && n < 3000) begin
            @(negedge BUS_CLK);
            n++;
        end
        if (!usb_valid) begin
            $display("%s: usb_valid never went high", name);
            timeouts++;
        end
    endtask

    // waits until the source stops popping for a while.
    task automatic wait_pops_stop(string name);
        int n;
        int quiet;
        n = 0;
        quiet = 0;
        while (quiet < 64 && n < 20000) begin
            @(negedge BUS_CLK);
            quiet = pop_seen ? 0 : quiet + 1;
            n++;
        end
        if (quiet < 64) begin
            $display("%s: the source kept being popped", name);
            timeouts++;
        end
    endtask

    task automatic drain(string name, int n);
        for (int i = 0; i < n; i++) begin
            wait_usb_valid(name);
            check_byte(name, (exp_q.size() > 0) ? exp_q.pop_front() : 8'h00, usb_data);
            usb_read = 1'b1;
            @(negedge BUS_CLK);
            usb_read = 1'b0;
        end
    endtask

    task automatic soft_reset();
        @(negedge BUS_CLK);
        bus_addr = REG_SOFT_RST;
        bus_wr   = 1'b1;
        @(negedge BUS_CLK);
        bus_wr = 1'b0;
        repeat (2) @(negedge BUS_CLK);
    endtask

    initial begin
        fill_t fill;
        byte_t val;
        BUS_CLK = 1'b0;
        RST = 1'b1;
        bus_addr = '0;
        bus_data_in = '0;
        bus_rd = 1'b0;
        bus_wr = 1'b0;
        fifo_empty = 1'b1;
        fifo_data = '0;
        usb_read = 1'b0;
        pop_seen = 1'b0;
        pop_cnt = 0;
        errors = 0;
        timeouts = 0;
        lcg_state = 32'h45d0fab9;
        repeat (5) @(posedge BUS_CLK);
        @(negedge BUS_CLK);
        RST = 1'b0;

        for (int r = 0; r < ROWS; r++) begin
            if (r != 0 && r != 5) begin
                soft_reset();
            end
            exp_q.delete();
            pop_cnt = 0;
            case (r)
                0: begin
                    check_byte("reset usb_valid", 8'h00, byte_t'(usb_valid));
                    check_byte("reset not_empty", 8'h00, byte_t'(fifo_not_empty));
                    check_byte("reset read_error", 8'h00, byte_t'(fifo_read_error));
                    read_fill(fill);
                    check_fill(t_name[r], fill_t'(t_exp[r]), fill);
                    read_reg(REG_READ_ERR, val);
                    check_err(t_name[r], err_cnt_t'(t_exp[r]), val);
                end
                1: begin
                    load_words(t_words[r]);
                    drain(t_name[r], t_reads[r]);
                end
                2: begin
                    load_words(t_words[r]);
                    wait_pops_stop(t_name[r]);
                    read_fill(fill);
                    check_fill(t_name[r], fill_t'(t_exp[r]), fill);
                    check_byte("fill not_empty", 8'h01, byte_t'(fifo_not_empty));
                    drain(t_name[r], t_reads[r]);
                    wait_usb_valid(t_name[r]);
                    read_fill(fill);
                    check_fill(t_name[r], fill_t'(t_exp[r] - t_reads[r] / 2), fill);
                end
                3: begin
                    load_words(t_words[r]);
                    wait_pops_stop(t_name[r]);
                    check_fill("full pops", fill_t'(512), fill_t'(pop_cnt));
                    read_fill(fill);
                    check_fill(t_name[r], fill_t'(t_exp[r]), fill);
                    drain(t_name[r], t_reads[r]);
                end
                4: begin
                    for (int i = 0; i < t_reads[r]; i++) begin
                        usb_read = 1'b1;
                        @(negedge BUS_CLK);
                        usb_read = 1'b0;
                        @(negedge BUS_CLK);
                    end
                    read_reg(REG_READ_ERR, val);
                    check_err(t_name[r], err_cnt_t'(t_exp[r]), val);
                    check_byte("underflow flag", 8'h01, byte_t'(fifo_read_error));
                end
                default: begin
                    load_words(t_words[r]);
                    wait_pops_stop(t_name[r]);
                    soft_reset();
                    check_byte("soft reset usb_valid", 8'h00, byte_t'(usb_valid));
                    check_byte("soft reset not_empty", 8'h00, byte_t'(fifo_not_empty));
                    read_fill(fill);
                    check_fill(t_name[r], fill_t'(t_exp[r]), fill);
                    read_reg(REG_READ_ERR, val);
                    check_err(t_name[r], err_cnt_t'(t_exp[r]), val);
                    exp_q.delete();
                    load_words(t_reads[r] / 4);
                    drain(t_name[r], t_reads[r]);
                end
            endcase
        end

        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
rtl/sram_fifo_pkg.sv
rtl/word_splitter.sv
rtl/sram_ring_ctrl.sv
rtl/byte_reader.sv
rtl/conf_regs.sv
rtl/sram_fifo_top.sv
testbench/sram_model.sv
testbench/sram_fifo_props.sv
testbench/tb_sram_fifo.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -Wall -Wno-fatal \
		--top-module tb_sram_fifo -f sim.f -o Vtb_sram_fifo
	@out="$$(./obj_dir/Vtb_sram_fifo)"; echo "$$out"; \
		echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
